/* Bender.yml */
package:
  name: branch_predictor

sources:
  - hdl/bp_pkg.sv
  - hdl/branch_target_buffer.sv
  - hdl/pattern_history_table.sv
  - hdl/prediction_stats.sv
  - hdl/fetch_sequencer.sv
  - hdl/branch_predictor_top.sv
  - target: test
    files:
      - testbench/branch_predictor_sva.sv
      - testbench/tb_branch_predictor.sv

/* hdl/bp_pkg.sv */
package bp_pkg;

    // Address geometry
    localparam int PC_W     = 32;
    localparam int ADDR_LSB = 2;                    // Word aligned fetch, low bits unused

    // Target buffer sizing
    localparam int BTB_IDX_W = 5;                   // 32 rows
    localparam int BTB_ROWS  = 2 ** BTB_IDX_W;
    localparam int BTB_TAG_W = PC_W - BTB_IDX_W - ADDR_LSB;

    // Pattern table sizing, history is as wide as the index
    localparam int PHT_IDX_W = 5;
    localparam int PHT_ROWS  = 2 ** PHT_IDX_W;
    localparam int PHT_TAG_W = PC_W - PHT_IDX_W - ADDR_LSB;

    localparam int CNT_W  = 2;                      // Saturating counter width
    localparam int STAT_W = 32;                     // Accuracy counter width

    // Fetch address generation
    localparam logic [PC_W-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [PC_W-1:0] PC_STEP  = 32'd4;

    // Two-bit direction counter
    typedef enum logic [CNT_W-1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1,
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } pred_cnt_e;

    // Fetch sequencer states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        REDIRECT
    } fetch_state_e;

endpackage

/* hdl/branch_predictor_top.sv */
`timescale 1ns/1ps

module branch_predictor_top (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  logic                       fetch_en_i,
    input  logic                       stall_i,

    input  logic                       resolve_valid_i,
    input  logic [bp_pkg::PC_W-1:0]    resolve_pc_i,
    input  logic                       resolve_taken_i,
    input  logic [bp_pkg::PC_W-1:0]    resolve_target_i,
    input  logic                       resolve_mispredict_i,

    output logic [bp_pkg::PC_W-1:0]    fetch_pc_o,
    output logic                       fetch_valid_o,
    output logic                       pred_taken_o,

    output logic [bp_pkg::STAT_W-1:0]  correct_count_o,
    output logic [bp_pkg::STAT_W-1:0]  wrong_count_o
);
    import bp_pkg::*;

    logic            btb_hit;
    logic [PC_W-1:0] btb_target;
    logic            pht_taken;

    fetch_sequencer i_fetch_sequencer (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .fetch_en_i           (fetch_en_i),
        .stall_i              (stall_i),
        .btb_hit_i            (btb_hit),
        .btb_target_i         (btb_target),
        .pht_taken_i          (pht_taken),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_pc_i         (resolve_pc_i),
        .resolve_taken_i      (resolve_taken_i),
        .resolve_target_i     (resolve_target_i),
        .fetch_pc_o           (fetch_pc_o),
        .fetch_valid_o        (fetch_valid_o),
        .pred_taken_o         (pred_taken_o)
    );

    // Both tables look up the registered fetch address
    branch_target_buffer i_branch_target_buffer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .lookup_pc_i  (fetch_pc_o),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_valid_i  (resolve_valid_i),
        .upd_pc_i     (resolve_pc_i),
        .upd_taken_i  (resolve_taken_i),
        .upd_target_i (resolve_target_i)
    );

    pattern_history_table i_pattern_history_table (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .lookup_pc_i (fetch_pc_o),
        .taken_o     (pht_taken),
        .upd_valid_i (resolve_valid_i),
        .upd_pc_i    (resolve_pc_i),
        .upd_taken_i (resolve_taken_i)
    );

    prediction_stats i_prediction_stats (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .resolve_valid_i (resolve_valid_i),
        .mispredict_i    (resolve_mispredict_i),
        .correct_count_o (correct_count_o),
        .wrong_count_o   (wrong_count_o)
    );

endmodule

/* hdl/branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic [bp_pkg::PC_W-1:0]  lookup_pc_i,
    output logic                     hit_o,
    output logic [bp_pkg::PC_W-1:0]  target_o,

    input  logic                     upd_valid_i,
    input  logic [bp_pkg::PC_W-1:0]  upd_pc_i,
    input  logic                     upd_taken_i,
    input  logic [bp_pkg::PC_W-1:0]  upd_target_i
);
    import bp_pkg::*;

    logic                 valid_q  [BTB_ROWS];
    logic [BTB_TAG_W-1:0] tag_q    [BTB_ROWS];
    logic [PC_W-1:0]      target_q [BTB_ROWS];

    logic [BTB_IDX_W-1:0] lookup_idx;
    logic [BTB_TAG_W-1:0] lookup_tag;
    logic [BTB_IDX_W-1:0] upd_idx;
    logic [BTB_TAG_W-1:0] upd_tag;

    // Split addresses into row index and tag above it
    assign lookup_idx = lookup_pc_i[ADDR_LSB +: BTB_IDX_W];
    assign lookup_tag = lookup_pc_i[PC_W-1 -: BTB_TAG_W];
    assign upd_idx    = upd_pc_i[ADDR_LSB +: BTB_IDX_W];
    assign upd_tag    = upd_pc_i[PC_W-1 -: BTB_TAG_W];

    // Combinational lookup on the current fetch address
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < BTB_ROWS; i++) begin
                valid_q[i]  <= 1'b0;
                tag_q[i]    <= '0;
                target_q[i] <= '0;
            end
        end else if (upd_valid_i) begin
            valid_q[upd_idx] <= 1'b1;
            tag_q[upd_idx]   <= upd_tag;                // Retag even on not-taken
            if (upd_taken_i) begin
                target_q[upd_idx] <= upd_target_i;      // Keep old target if not taken
            end
        end
    end

endmodule

/* hdl/fetch_sequencer.sv */
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic                     fetch_en_i,
    input  logic                     stall_i,

    input  logic                     btb_hit_i,
    input  logic [bp_pkg::PC_W-1:0]  btb_target_i,
    input  logic                     pht_taken_i,

    input  logic                     resolve_valid_i,
    input  logic                     resolve_mispredict_i,
    input  logic [bp_pkg::PC_W-1:0]  resolve_pc_i,
    input  logic                     resolve_taken_i,
    input  logic [bp_pkg::PC_W-1:0]  resolve_target_i,

    output logic [bp_pkg::PC_W-1:0]  fetch_pc_o,
    output logic                     fetch_valid_o,
    output logic                     pred_taken_o
);
    import bp_pkg::*;

    fetch_state_e    state_q;
    fetch_state_e    state_d;
    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_d;

    logic            redirect;
    logic [PC_W-1:0] redirect_pc;
    logic            pred_taken;

    // Execute found a wrong prediction, fetch must restart
    assign redirect    = resolve_valid_i && resolve_mispredict_i;
    assign redirect_pc = resolve_taken_i ? resolve_target_i : resolve_pc_i + PC_STEP;

    // Both tables must agree before fetch follows a branch
    assign pred_taken = btb_hit_i && pht_taken_i;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        if (redirect) begin                             // Wins over stall and prediction
            state_d = REDIRECT;
            pc_d    = redirect_pc;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fetch_en_i) begin
                        state_d = RUN;
                    end
                end
                RUN: begin
                    if (!fetch_en_i) begin
                        state_d = IDLE;                 // Address is kept
                    end else if (!stall_i) begin
                        pc_d = pred_taken ? btb_target_i : pc_q + PC_STEP;
                    end
                end
                REDIRECT: begin
                    state_d = RUN;                      // Corrected address fetched next cycle
                end
                default: begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign fetch_pc_o    = pc_q;
    assign fetch_valid_o = (state_q == RUN);
    assign pred_taken_o  = fetch_valid_o && pred_taken;   // Only valid fetches carry a prediction

endmodule

/* hdl/pattern_history_table.sv */
`timescale 1ns/1ps

module pattern_history_table (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic [bp_pkg::PC_W-1:0]  lookup_pc_i,
    output logic                     taken_o,

    input  logic                     upd_valid_i,
    input  logic [bp_pkg::PC_W-1:0]  upd_pc_i,
    input  logic                     upd_taken_i
);
    import bp_pkg::*;

    logic [PHT_IDX_W-1:0] ghr_q;                    // Global history, newest outcome in bit 0
    logic [PHT_TAG_W-1:0] tag_q [PHT_ROWS];
    pred_cnt_e            cnt_q [PHT_ROWS];

    logic [PHT_IDX_W-1:0] lookup_idx;
    logic [PHT_TAG_W-1:0] lookup_tag;
    logic [PHT_IDX_W-1:0] upd_idx;
    logic [PHT_TAG_W-1:0] upd_tag;
    pred_cnt_e            lookup_cnt;
    pred_cnt_e            upd_cnt_next;

    // Move one step toward the outcome, saturating at both ends
    function automatic pred_cnt_e cnt_step(input pred_cnt_e cnt, input logic taken);
        pred_cnt_e nxt;
        nxt = cnt;
        case (cnt)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = STRONG_NT;
        endcase
        return nxt;
    endfunction

    // gshare index for both lookup and training
    assign lookup_idx = lookup_pc_i[ADDR_LSB +: PHT_IDX_W] ^ ghr_q;
    assign lookup_tag = lookup_pc_i[PC_W-1 -: PHT_TAG_W];
    assign upd_idx    = upd_pc_i[ADDR_LSB +: PHT_IDX_W] ^ ghr_q;
    assign upd_tag    = upd_pc_i[PC_W-1 -: PHT_TAG_W];

    assign lookup_cnt = cnt_q[lookup_idx];
    assign taken_o    = (tag_q[lookup_idx] == lookup_tag)
                        && (lookup_cnt == WEAK_T || lookup_cnt == STRONG_T);

    // Old counter is stepped regardless of whether its tag matched
    assign upd_cnt_next = cnt_step(cnt_q[upd_idx], upd_taken_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ghr_q <= '0;
            for (int i = 0; i < PHT_ROWS; i++) begin
                tag_q[i] <= '0;
                cnt_q[i] <= STRONG_NT;
            end
        end else if (upd_valid_i) begin
            tag_q[upd_idx] <= upd_tag;
            cnt_q[upd_idx] <= upd_cnt_next;
            ghr_q          <= {ghr_q[PHT_IDX_W-2:0], upd_taken_i};  // Shift in the outcome
        end
    end

endmodule

/* hdl/prediction_stats.sv */
`timescale 1ns/1ps

module prediction_stats (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  logic                       resolve_valid_i,
    input  logic                       mispredict_i,

    output logic [bp_pkg::STAT_W-1:0]  correct_count_o,
    output logic [bp_pkg::STAT_W-1:0]  wrong_count_o
);
    import bp_pkg::*;

    logic [STAT_W-1:0] correct_q;
    logic [STAT_W-1:0] wrong_q;

    // Exactly one of the two counters moves per resolved branch
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            correct_q <= '0;
            wrong_q   <= '0;
        end else if (resolve_valid_i) begin
            if (mispredict_i) begin
                wrong_q <= wrong_q + 1'b1;              // Wraps on overflow
            end else begin
                correct_q <= correct_q + 1'b1;
            end
        end
    end

    assign correct_count_o = correct_q;
    assign wrong_count_o   = wrong_q;

endmodule

/* src.f */
hdl/bp_pkg.sv
hdl/branch_target_buffer.sv
hdl/pattern_history_table.sv
hdl/prediction_stats.sv
hdl/fetch_sequencer.sv
hdl/branch_predictor_top.sv
testbench/branch_predictor_sva.sv
testbench/tb_branch_predictor.sv

/* testbench/branch_predictor_sva.sv */
`timescale 1ns/1ps

module branch_predictor_top_sva (
    input logic        clk_i,
    input logic        rstn_i,
    input logic        stall_i,
    input logic        resolve_valid_i,
    input logic        resolve_mispredict_i,
    input logic [31:0] fetch_pc_o,
    input logic        fetch_valid_o,
    input logic        pred_taken_o,
    input logic [31:0] correct_count_o,
    input logic [31:0] wrong_count_o
);
    logic [31:0] total;

    assign total = correct_count_o + wrong_count_o;

    // Synchronous reset leaves fetch idle
    assert property (@(posedge clk_i) !rstn_i |=> !fetch_valid_o)
        else $error("fetch_valid_o high after reset");

    // One bubble after a mispredict
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        resolve_valid_i && resolve_mispredict_i |=> !fetch_valid_o)
        else $error("fetch_valid_o high after mispredict");

    assert property (@(posedge clk_i) disable iff (!rstn_i) pred_taken_o |-> fetch_valid_o)
        else $error("pred_taken_o without fetch_valid_o");

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_valid_o && stall_i && !(resolve_valid_i && resolve_mispredict_i)
        |=> $stable(fetch_pc_o))
        else $error("fetch_pc_o moved during stall");

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        resolve_valid_i |=> total == $past(total) + 32'd1)
        else $error("statistics did not advance by one");

endmodule

bind branch_predictor_top branch_predictor_top_sva i_sva (.*);

/* testbench/tb_branch_predictor.sv */
`timescale 1ns/1ps

module tb_branch_predictor;
    logic        clk_i;
    logic        rstn_i;
    logic        fetch_en_i;
    logic        stall_i;
    logic        resolve_valid_i;
    logic [31:0] resolve_pc_i;
    logic        resolve_taken_i;
    logic [31:0] resolve_target_i;
    logic        resolve_mispredict_i;
    logic [31:0] fetch_pc_o;
    logic        fetch_valid_o;
    logic        pred_taken_o;
    logic [31:0] correct_count_o;
    logic [31:0] wrong_count_o;

    // Reference model state encoded as 0 idle, 1 run and 2 redirect
    int          m_state;
    logic [31:0] m_pc;
    logic        m_btb_v   [32];
    logic [24:0] m_btb_tag [32];
    logic [31:0] m_btb_tgt [32];
    logic [24:0] m_pht_tag [32];
    int          m_pht_cnt [32];
    logic [4:0]  m_ghr;
    logic [31:0] m_correct;
    logic [31:0] m_wrong;
    // Inputs driven last cycle, applied to the model at the following edge
    logic        p_en, p_stall, p_rv, p_rt, p_rm;
    logic [31:0] p_rpc, p_rtgt;

    int          errors;
    int          cycles;
    logic [15:0] lfsr;

    branch_predictor_top i_dut (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= 600) begin
            $display("Timeout: the tests did not finish within 600 cycles");
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // Taps 16,14,13,11
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Two tags share all 32 rows, so aliasing is frequent
    function automatic logic [31:0] rand_pc();
        logic [31:0] pc;
        pc = next_bit() ? 32'h0000_1000 : 32'h0000_0000;
        return pc | (rand_bits(5) << 2);
    endfunction

    function automatic logic model_pred(input logic [31:0] pc);
        logic [4:0] bi;
        logic [4:0] pi;
        bi = pc[6:2];
        pi = pc[6:2] ^ m_ghr;
        return m_btb_v[bi] && (m_btb_tag[bi] == pc[31:7])
               && (m_pht_tag[pi] == pc[31:7]) && (m_pht_cnt[pi] >= 2);
    endfunction

    task automatic model_edge();
        logic       pred;
        logic [4:0] pi;
        pred = model_pred(m_pc);
        if (p_rv && p_rm) begin
            m_state = 2;
            m_pc    = p_rt ? p_rtgt : p_rpc + 4;
        end else if (m_state == 0) begin
            if (p_en) m_state = 1;
        end else if (m_state == 1) begin
            if (!p_en) m_state = 0;
            else if (!p_stall) m_pc = pred ? m_btb_tgt[m_pc[6:2]] : m_pc + 4;
        end else begin
            m_state = 1;
        end
        if (p_rv) begin
            m_btb_v[p_rpc[6:2]]   = 1'b1;
            m_btb_tag[p_rpc[6:2]] = p_rpc[31:7];
            if (p_rt) m_btb_tgt[p_rpc[6:2]] = p_rtgt;
            pi = p_rpc[6:2] ^ m_ghr;
            m_pht_tag[pi] = p_rpc[31:7];
            if (p_rt && m_pht_cnt[pi] < 3) m_pht_cnt[pi]++;
            if (!p_rt && m_pht_cnt[pi] > 0) m_pht_cnt[pi]--;
            m_ghr = {m_ghr[3:0], p_rt};
            if (p_rm) m_wrong++;
            else m_correct++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("Fail %s: got %h expected %h at %0t", name, act, exp, $time);
            errors++;
        end
    endtask

    task automatic check_outputs();
        logic valid;
        valid = (m_state == 1);
        check_value("fetch_pc_o", fetch_pc_o, m_pc);
        check_value("fetch_valid_o", fetch_valid_o, valid);
        check_value("pred_taken_o", pred_taken_o, valid && model_pred(m_pc));
        check_value("correct_count_o", correct_count_o, m_correct);
        check_value("wrong_count_o", wrong_count_o, m_wrong);
    endtask

    // Model the previous inputs, drive new ones and check at the falling edge
    task automatic cycle(input logic en, input logic stall, input logic rv,
                         input logic [31:0] rpc, input logic rt,
                         input logic [31:0] rtgt, input logic rm);
        @(posedge clk_i);
        model_edge();
        fetch_en_i           <= en;
        stall_i              <= stall;
        resolve_valid_i      <= rv;
        resolve_pc_i         <= rpc;
        resolve_taken_i      <= rt;
        resolve_target_i     <= rtgt;
        resolve_mispredict_i <= rm;
        {p_en, p_stall, p_rv, p_rpc, p_rt, p_rtgt, p_rm} = {en, stall, rv, rpc, rt, rtgt, rm};
        @(negedge clk_i);
        check_outputs();
    endtask

    task automatic test_reset_and_sequential();
        check_outputs();
        repeat (8) cycle(1, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic test_training();
        cycle(0, 0, 0, 0, 0, 0, 0);
        repeat (8) cycle(0, 0, 1, 32'h40, 1, 32'h200, 0);
        cycle(1, 0, 1, 32'h100, 1, 32'h40, 1);          // Redirect onto the branch
        repeat (2) cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("pred_taken_o", pred_taken_o, 1'b1);
        cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("fetch_pc_o", fetch_pc_o, 32'h200);  // Followed the trained target
        repeat (2) cycle(1, 0, 0, 0, 0, 0, 0);
        cycle(0, 0, 0, 0, 0, 0, 0);
        repeat (5) cycle(0, 0, 1, 32'h40, 0, 32'h0, 0);
        cycle(1, 0, 1, 32'h3c, 0, 32'h0, 1);
        repeat (2) cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("pred_taken_o", pred_taken_o, 1'b0);
        cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("fetch_pc_o", fetch_pc_o, 32'h44);
        repeat (2) cycle(1, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic test_mispredict();
        cycle(1, 0, 1, 32'h80, 1, 32'h300, 1);
        cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("fetch_valid_o", fetch_valid_o, 1'b0);
        check_value("fetch_pc_o", fetch_pc_o, 32'h300);
        cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("fetch_valid_o", fetch_valid_o, 1'b1);
        check_value("fetch_pc_o", fetch_pc_o, 32'h300);
        cycle(1, 0, 1, 32'h500, 0, 32'h900, 1);
        cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("fetch_valid_o", fetch_valid_o, 1'b0);
        check_value("fetch_pc_o", fetch_pc_o, 32'h504);
        cycle(1, 0, 0, 0, 0, 0, 0);
        check_value("fetch_valid_o", fetch_valid_o, 1'b1);
        check_value("fetch_pc_o", fetch_pc_o, 32'h504);
    endtask

    task automatic test_stall();
        repeat (4) cycle(1, 1, 0, 0, 0, 0, 0);
        cycle(1, 1, 1, 32'h600, 1, 32'h700, 1);         // Redirect wins over stall
        repeat (3) cycle(1, 1, 0, 0, 0, 0, 0);
        repeat (3) cycle(1, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic test_statistics();
        logic [31:0] c0;
        logic [31:0] w0;
        int          nc;
        int          nw;
        logic        rm;
        c0 = correct_count_o;
        w0 = wrong_count_o;
        nc = 0;
        nw = 0;
        for (int i = 0; i < 40; i++) begin
            rm = next_bit();
            if (rm) nw++;
            else nc++;
            cycle(0, 0, 1, rand_pc(), next_bit(), rand_bits(8) << 2, rm);
            cycle(0, 0, 0, 0, 0, 0, 0);
        end
        check_value("correct_count_o", correct_count_o, c0 + nc);
        check_value("wrong_count_o", wrong_count_o, w0 + nw);
    endtask

    task automatic test_aliasing();
        repeat (60) cycle(0, 0, 1, rand_pc(), next_bit(), rand_pc(), 0);
        cycle(1, 0, 1, 32'hffff_fffc, 0, 32'h0, 1);
        for (int i = 0; i < 80; i++) begin
            cycle(1, 0, next_bit(), rand_pc(), next_bit(), rand_pc(), 0);
        end
        cycle(0, 0, 0, 0, 0, 0, 0);
    endtask

    initial begin
        lfsr   = 16'd14276;
        errors = 0;
        cycles = 0;
        clk_i  = 1'b0;
        rstn_i = 1'b0;
        {fetch_en_i, stall_i, resolve_valid_i, resolve_taken_i, resolve_mispredict_i} = '0;
        resolve_pc_i     = '0;
        resolve_target_i = '0;
        {p_en, p_stall, p_rv, p_rt, p_rm, p_rpc, p_rtgt} = '0;
        m_state   = 0;
        m_pc      = 32'h0;
        m_ghr     = '0;
        m_correct = '0;
        m_wrong   = '0;
        for (int i = 0; i < 32; i++) begin
            m_btb_v[i]   = 1'b0;
            m_btb_tag[i] = '0;
            m_btb_tgt[i] = '0;
            m_pht_tag[i] = '0;
            m_pht_cnt[i] = 0;
        end
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        test_reset_and_sequential();
        test_training();
        test_mispredict();
        test_stall();
        test_statistics();
        test_aliasing();
        $display("Run complete after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
